// File: vlog.f
common/img_pkg.sv
common/track_pkg.sv
hdl/frame_buf.sv
color_proc/color_filter.sv
color_proc/red_hist.sv
color_proc/centroid_calc.sv
color_proc/color_proc.sv
hdl/led_track_top.sv
verification/tb_led_track.sv

// File: Makefile
# Verilator build and run for the red-object tracker
# any variable can be overridden, e.g. make run LOG=other.log

VERILATOR ?= verilator
TOP       ?= tb_led_track
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL TESTS PASSED
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal

.PHONY: all compile run clean

all: run

# build the simulation executable
compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# run and decide pass or fail from the log
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
	  echo "simulation passed"; \
	else \
	  echo "simulation failed"; \
	  exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_led_track.sv
module tb_led_track;

  timeunit 1ns;
  timeprecision 100ps;

  import img_pkg::*;
  import track_pkg::*;

  localparam int unsigned min_pxls = 32;
  localparam int n_scenes      = 8;
  localparam int pulse_timeout = 10000; // cycles per wait for new_centroid
  localparam int n_probes      = 10;    // display reads per scene

  // each scene gives background, red rectangle, filter code and the led pattern it should give
  typedef struct packed {
    pxl_t    bg;
    logic    noise;    // randomize green and blue of the background
    int      col_lo;
    int      col_hi;
    int      row_lo;
    int      row_hi;
    pxl_t    red;
    filter_t code;
    led_t    exp_leds;
  } scene_t;

  scene_t scenes [n_scenes] = '{
    '{12'h000, 1'b1,  8, 15, 10, 19, 12'hF00, 3'b000, 8'h01}, // bin 0 only
    '{12'h000, 1'b1, 56, 69, 20, 29, 12'h812, 3'b001, 8'h40}, // bins 6 and 7
    '{12'h300, 1'b1, 48, 55, 30, 39, 12'hC38, 3'b010, 8'h20}, // bin 5 only
    '{12'h000, 1'b1, 32, 47, 20, 29, 12'hA00, 3'b011, 8'h18}, // centered
    '{12'h000, 1'b1, 20, 27, 10, 13, 12'hF11, 3'b100, 8'h00}, // exactly 32 pixels, noise
    '{12'h000, 1'b1, 72, 79,  0, 59, 12'h955, 3'b101, 8'h00}, // right border only
    '{12'h7FF, 1'b0, 10, 29, 40, 49, 12'hE80, 3'b110, 8'h02}, // bins 0..2, mostly 1
    '{12'h000, 1'b1, 30, 39,  6, 53, 12'h801, 3'b111, 8'h08}  // wide, bins 2 and 3
  };

  logic      clk;
  logic      rst;
  filter_t   rgbfilter;
  logic      cam_we;
  pxl_addr_t cam_addr;
  pxl_t      cam_pxl;
  pxl_addr_t disp_addr;
  pxl_t      disp_pxl;
  led_t      leds;
  logic      new_centroid;

  pxl_t        frame [img_pxls]; // copy of what was written to the camera side
  led_t        leds_prev;
  int          mismatches;
  int          table_errs;
  int          timeouts;
  int          cycles;
  led_t        model;

  led_track_top #(
    .min_color_pxls (min_pxls)
  ) i_led_track_top (
    .clk          (clk),
    .rst          (rst),
    .rgbfilter    (rgbfilter),
    .cam_we       (cam_we),
    .cam_addr     (cam_addr),
    .cam_pxl      (cam_pxl),
    .disp_addr    (disp_addr),
    .disp_pxl     (disp_pxl),
    .leds         (leds),
    .new_centroid (new_centroid)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk; // 100 MHz
  end

  // red means red msb set, green and blue below 9
  function automatic logic red_rule(input pxl_t p);
    return p[11] && (p[7:4] < 4'd9) && (p[3:0] < 4'd9);
  endfunction

  // reference display filter, black when the pixel is rejected
  function automatic pxl_t filter_rule(input pxl_t p, input filter_t code);
    logic keep;
    if (code == 3'b000) keep = 1'b1;
    else if (code == 3'b100) keep = red_rule(p); // detector mode
    else keep = (!code[2] || p[11]) && (!code[1] || p[7]) && (!code[0] || p[3]);
    return keep ? p : 12'h000;
  endfunction

  // histogram of the stored frame and the led decision
  function automatic led_t model_pattern();
    int   hist [8];
    int   total;
    int   lsum;
    int   rsum;
    int   half;
    int   diff;
    int   col;
    int   row;
    led_t pat;
    for (int b = 0; b < 8; b++) hist[b] = 0;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      if (col >= 8 && col <= 71 && row >= 6 && row <= 53 && red_rule(frame[a]))
        hist[(col - 8) / 8]++; // 8 columns per bin
    end
    total = 0;
    for (int b = 0; b < 8; b++) total += hist[b];
    lsum = hist[0] + hist[1] + hist[2] + hist[3];
    rsum = hist[4] + hist[5] + hist[6] + hist[7];
    diff = (lsum > rsum) ? lsum - rsum : rsum - lsum;
    half = total / 2;
    pat  = 8'h00;
    if (total <= int'(min_pxls)) pat = 8'h00;      // too few, noise
    else if (diff < total / 16) pat = 8'h18;       // middle pair
    else if (lsum > rsum) begin
      if (hist[0] >= half) pat[0] = 1'b1;
      else if (hist[0] + hist[1] >= half) pat[1] = 1'b1;
      else if (hist[0] + hist[1] + hist[2] >= half) pat[2] = 1'b1;
      else if (lsum > half) pat[3] = 1'b1;
    end else begin
      if (hist[7] >= half) pat[7] = 1'b1;
      else if (hist[7] + hist[6] >= half) pat[6] = 1'b1;
      else if (hist[7] + hist[6] + hist[5] >= half) pat[5] = 1'b1;
      else if (rsum > half) pat[4] = 1'b1;
    end
    return pat;
  endfunction

  // whole frame through the camera port, one pixel per clock
  task automatic write_frame(input int s);
    pxl_t        p;
    int          col;
    int          row;
    logic [31:0] rnd;
    for (int a = 0; a < img_pxls; a++) begin
      col = a % img_cols;
      row = a / img_cols;
      rnd = $urandom();
      if (col >= scenes[s].col_lo && col <= scenes[s].col_hi &&
          row >= scenes[s].row_lo && row <= scenes[s].row_hi) p = scenes[s].red;
      else if (scenes[s].noise) p = {1'b0, scenes[s].bg[10:8], rnd[7:0]}; // never red
      else p = scenes[s].bg;
      frame[a] = p;
      @(posedge clk);
      cam_we   <= 1'b1;
      cam_addr <= pxl_addr_t'(a);
      cam_pxl  <= p;
    end
    @(posedge clk);
    cam_we <= 1'b0;
  endtask

  // cycles counted at falling edges, -1 on timeout
  task automatic wait_pulse(input int s, output int n);
    logic seen;
    seen = 1'b0;
    n    = 0;
    while (!seen && n < pulse_timeout) begin
      @(negedge clk);
      n++;
      seen = new_centroid;
    end
    if (!seen) begin
      $display("new_centroid never arrived in scene %0d", s);
      timeouts++;
      n = -1;
    end
  endtask

  // a few addresses read back through the display port
  task automatic check_display(input int s);
    int   a;
    pxl_t exp;
    for (int k = 0; k < n_probes; k++) begin
      if (k == 0) a = 0;
      else if (k == 1) a = img_pxls - 1;
      else if (k == 2) a = scenes[s].row_lo * img_cols + scenes[s].col_lo; // rectangle corner
      else a = int'($urandom_range(img_pxls - 1));
      @(posedge clk);
      disp_addr <= pxl_addr_t'(a);
      @(posedge clk);               // ram registers the read here
      @(negedge clk);
      exp = filter_rule(frame[a], scenes[s].code);
      if (disp_pxl !== exp) begin
        $display("mismatch at %0t: scene %0d disp addr %0d got %h expected %h",
                 $time, s, a, disp_pxl, exp);
        mismatches++;
      end
    end
  endtask

  // leds may only move together with a pulse
  always @(negedge clk) begin
    if (!rst && leds !== leds_prev && !new_centroid) begin
      $display("mismatch at %0t: leds changed from %h to %h without new_centroid",
               $time, leds_prev, leds);
      mismatches++;
    end
    leds_prev = leds;
  end

  initial begin
    mismatches = 0;
    table_errs = 0;
    timeouts   = 0;
    leds_prev  = '0;
    void'($urandom(43999)); // single seed for the run
    rst       <= 1'b1;
    rgbfilter <= 3'b000;
    cam_we    <= 1'b0;
    cam_addr  <= '0;
    cam_pxl   <= '0;
    disp_addr <= '0;
    repeat (4) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    if (leds !== 8'h00 || new_centroid !== 1'b0) begin
      $display("mismatch at %0t: after reset leds %h new_centroid %b", $time, leds, new_centroid);
      mismatches++;
    end
    wait_pulse(-1, cycles); // first frame, nothing written yet
    if (cycles >= 0 && cycles != img_pxls) begin
      $display("mismatch at %0t: first new_centroid %0d cycles after reset, expected %0d",
               $time, cycles, img_pxls);
      mismatches++;
    end

    for (int s = 0; s < n_scenes; s++) begin
      @(posedge clk);
      rgbfilter <= scenes[s].code;
      write_frame(s);
      wait_pulse(s, cycles); // this frame may still be mixed
      wait_pulse(s, cycles); // fully the new frame
      if (cycles >= 0 && cycles != img_pxls) begin
        $display("mismatch at %0t: scene %0d pulses %0d cycles apart", $time, s, cycles);
        mismatches++;
      end
      model = model_pattern();
      if (model !== scenes[s].exp_leds) begin
        $display("table error: scene %0d lists %h but the model gives %h",
                 s, scenes[s].exp_leds, model);
        table_errs++;
      end
      if (leds !== scenes[s].exp_leds) begin
        $display("mismatch at %0t: scene %0d leds %h expected %h",
                 $time, s, leds, scenes[s].exp_leds);
        mismatches++;
      end
      check_display(s);
    end

    $display("errors: %0d mismatches, %0d table errors, %0d timeouts",
             mismatches, table_errs, timeouts);
    if (mismatches == 0 && table_errs == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: hdl/led_track_top.sv
module led_track_top #(
  parameter int unsigned min_color_pxls = 32 // red pixels needed for a detection
) (
  input  logic               clk,
  input  logic               rst,
  input  img_pkg::filter_t   rgbfilter,
  input  logic               cam_we,       // camera side write
  input  img_pkg::pxl_addr_t cam_addr,
  input  img_pkg::pxl_t      cam_pxl,
  input  img_pkg::pxl_addr_t disp_addr,    // display side read
  output img_pkg::pxl_t      disp_pxl,
  output track_pkg::led_t    leds,
  output logic               new_centroid
);

  import img_pkg::*;

  pxl_addr_t orig_addr; // scan read address
  pxl_t      orig_pxl;
  logic      proc_we;
  pxl_addr_t proc_addr;
  pxl_t      proc_pxl;

  // frame as written by the camera
  frame_buf i_orig_buf (
    .clk     (clk),
    .we      (cam_we),
    .wr_addr (cam_addr),
    .wr_pxl  (cam_pxl),
    .rd_addr (orig_addr),
    .rd_pxl  (orig_pxl)
  );

  color_proc #(
    .min_color_pxls (min_color_pxls)
  ) i_color_proc (
    .clk          (clk),
    .rst          (rst),
    .rgbfilter    (rgbfilter),
    .orig_pxl     (orig_pxl),
    .orig_addr    (orig_addr),
    .proc_we      (proc_we),
    .proc_pxl     (proc_pxl),
    .proc_addr    (proc_addr),
    .centroid     (leds),
    .new_centroid (new_centroid)
  );

  // filtered frame for the display
  frame_buf i_proc_buf (
    .clk     (clk),
    .we      (proc_we),
    .wr_addr (proc_addr),
    .wr_pxl  (proc_pxl),
    .rd_addr (disp_addr),
    .rd_pxl  (disp_pxl)
  );

endmodule

// File: color_proc/color_proc.sv
module color_proc #(
  parameter int unsigned min_color_pxls = 32
) (
  input  logic               clk,
  input  logic               rst,
  input  img_pkg::filter_t   rgbfilter,
  input  img_pkg::pxl_t      orig_pxl,    // arrives one clock after orig_addr
  output img_pkg::pxl_addr_t orig_addr,
  output logic               proc_we,
  output img_pkg::pxl_t      proc_pxl,
  output img_pkg::pxl_addr_t proc_addr,   // orig_addr delayed by one
  output track_pkg::led_t    centroid,
  output logic               new_centroid
);

  import img_pkg::*;
  import track_pkg::*;

  pxl_addr_t  cnt_pxl;   // scan position, 0..4799
  col_t       col;       // column of cnt_pxl
  row_t       row;
  col_t       col_d;     // aligned with orig_pxl
  row_t       row_d;
  logic       frame_end; // last pixel address of the frame
  logic       end_ln;    // last column of a line
  logic       is_red;

  hist_cnt_t  hist0, hist7;
  total_cnt_t total;
  side_cnt_t  left_sum, right_sum;
  side_cnt_t  bin01, bin012, bin67, bin567;

  assign frame_end = (cnt_pxl == pxl_addr_t'(img_pxls - 1));
  assign end_ln    = (col == col_t'(img_cols - 1));
  assign orig_addr = cnt_pxl;

  // free running scan, write side trails the read side by a clock
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      cnt_pxl   <= '0;
      proc_addr <= '0;
      proc_we   <= 1'b0;
    end else begin
      proc_we   <= 1'b1;        // stays high from here on
      proc_addr <= cnt_pxl;
      cnt_pxl   <= frame_end ? '0 : cnt_pxl + 1'b1;
    end
  end

  // column and row follow cnt_pxl
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      col <= '0;
      row <= '0;
    end else begin
      col <= end_ln ? '0 : col + 1'b1;
      if (frame_end) row <= '0;
      else if (end_ln) row <= row + 1'b1;
    end
  end

  // both delayed together to match the read latency
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      col_d <= '0;
      row_d <= '0;
    end else begin
      col_d <= col;
      row_d <= row;
    end
  end

  color_filter i_color_filter (
    .orig_pxl  (orig_pxl),
    .rgbfilter (rgbfilter),
    .proc_pxl  (proc_pxl),
    .is_red    (is_red)
  );

  red_hist i_red_hist (
    .clk       (clk),
    .rst       (rst),
    .is_red    (is_red),
    .col_d     (col_d),
    .row_d     (row_d),
    .frame_end (frame_end),
    .hist0     (hist0),
    .hist7     (hist7),
    .total     (total),
    .left_sum  (left_sum),
    .right_sum (right_sum),
    .bin01     (bin01),
    .bin012    (bin012),
    .bin67     (bin67),
    .bin567    (bin567)
  );

  centroid_calc #(
    .min_color_pxls (min_color_pxls)
  ) i_centroid_calc (
    .clk          (clk),
    .rst          (rst),
    .frame_end    (frame_end),
    .hist0        (hist0),
    .hist7        (hist7),
    .total        (total),
    .left_sum     (left_sum),
    .right_sum    (right_sum),
    .bin01        (bin01),
    .bin012       (bin012),
    .bin67        (bin67),
    .bin567       (bin567),
    .centroid     (centroid),
    .new_centroid (new_centroid)
  );

endmodule

// File: color_proc/centroid_calc.sv
module centroid_calc #(
  parameter int unsigned min_color_pxls = 32 // below this it is noise
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  frame_end,
  input  track_pkg::hist_cnt_t  hist0,
  input  track_pkg::hist_cnt_t  hist7,
  input  track_pkg::total_cnt_t total,
  input  track_pkg::side_cnt_t  left_sum,
  input  track_pkg::side_cnt_t  right_sum,
  input  track_pkg::side_cnt_t  bin01,
  input  track_pkg::side_cnt_t  bin012,
  input  track_pkg::side_cnt_t  bin67,
  input  track_pkg::side_cnt_t  bin567,
  output track_pkg::led_t       centroid,    // latched pattern
  output logic                  new_centroid // one clock per frame
);

  import track_pkg::*;

  logic      left;      // more red on the left half
  side_cnt_t abs_diff;  // |left - right|
  side_cnt_t half;      // total / 2
  side_cnt_t sixteenth; // total / 16, margin for the middle
  led_t      pattern;

  assign left      = left_sum > right_sum;
  assign abs_diff  = left ? (left_sum - right_sum) : (right_sum - left_sum);
  assign half      = side_cnt_t'(total >> 1);
  assign sixteenth = side_cnt_t'(total >> 4);

  always_comb begin
    pattern = '0;
    if (32'(total) <= min_color_pxls) begin
      pattern = '0;                           // nothing detected
    end else if (abs_diff < sixteenth) begin
      pattern[4:3] = 2'b11;                   // roughly centered
    end else if (left) begin
      // walk in from the left edge
      if (side_cnt_t'(hist0) >= half) pattern[0] = 1'b1;
      else if (bin01 >= half)         pattern[1] = 1'b1;
      else if (bin012 >= half)        pattern[2] = 1'b1;
      else if (left_sum > half)       pattern[3] = 1'b1;
    end else begin
      // mirror image from the right edge
      if (side_cnt_t'(hist7) >= half) pattern[7] = 1'b1;
      else if (bin67 >= half)         pattern[6] = 1'b1;
      else if (bin567 >= half)        pattern[5] = 1'b1;
      else if (right_sum > half)      pattern[4] = 1'b1;
    end
  end

  // sums are still complete in the frame_end cycle
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      centroid     <= '0;
      new_centroid <= 1'b0;
    end else begin
      new_centroid <= frame_end;
      if (frame_end) centroid <= pattern;
    end
  end

endmodule

// File: color_proc/red_hist.sv
module red_hist (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  is_red,    // current pixel is red
  input  img_pkg::col_t         col_d,     // column of the current pixel
  input  img_pkg::row_t         row_d,     // row of the current pixel
  input  logic                  frame_end, // clears everything
  output track_pkg::hist_cnt_t  hist0,     // leftmost bin
  output track_pkg::hist_cnt_t  hist7,     // rightmost bin
  output track_pkg::total_cnt_t total,     // all red pixels in the inner frame
  output track_pkg::side_cnt_t  left_sum,  // bins 0..3
  output track_pkg::side_cnt_t  right_sum, // bins 4..7
  output track_pkg::side_cnt_t  bin01,
  output track_pkg::side_cnt_t  bin012,
  output track_pkg::side_cnt_t  bin67,
  output track_pkg::side_cnt_t  bin567
);

  import img_pkg::*;
  import track_pkg::*;

  hist_cnt_t hist [hist_bins]; // red count per column bin
  logic      in_frame;
  logic      hit;              // red pixel inside the inner frame
  col_t      col_in;           // column relative to the inner frame
  bin_t      bin;

  assign in_frame = (col_d >= col_t'(inframe_col_lo)) && (col_d <= col_t'(inframe_col_hi)) &&
                    (row_d >= row_t'(inframe_row_lo)) && (row_d <= row_t'(inframe_row_hi));

  assign col_in = col_d - col_t'(inframe_col_lo); // garbage outside, not used then
  assign bin    = bin_t'(col_in >> bin_shift);
  assign hit    = is_red & in_frame;

  // side sums are counted directly instead of adding bins later
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < hist_bins; i++) begin
        hist[i] <= '0;
      end
      total     <= '0;
      left_sum  <= '0;
      right_sum <= '0;
      bin01     <= '0;
      bin012    <= '0;
      bin67     <= '0;
      bin567    <= '0;
    end else if (frame_end) begin // new frame starts from zero
      for (int i = 0; i < hist_bins; i++) begin
        hist[i] <= '0;
      end
      total     <= '0;
      left_sum  <= '0;
      right_sum <= '0;
      bin01     <= '0;
      bin012    <= '0;
      bin67     <= '0;
      bin567    <= '0;
    end else if (hit) begin
      hist[bin] <= hist[bin] + 1'b1;
      total     <= total + 1'b1;
      if (bin < bin_t'(hist_bins / 2)) begin
        left_sum <= left_sum + 1'b1;   // 0123
      end else begin
        right_sum <= right_sum + 1'b1; // 4567
      end
      if (bin <= 3'd1) bin01  <= bin01 + 1'b1;
      if (bin <= 3'd2) bin012 <= bin012 + 1'b1;
      if (bin >= 3'd6) bin67  <= bin67 + 1'b1;
      if (bin >= 3'd5) bin567 <= bin567 + 1'b1;
    end
  end

  // only the edge bins are needed by the decision
  assign hist0 = hist[0];
  assign hist7 = hist[hist_bins-1];

endmodule

// File: color_proc/color_filter.sv
module color_filter (
  input  img_pkg::pxl_t    orig_pxl,  // pixel from the original frame
  input  img_pkg::filter_t rgbfilter, // selected display filter
  output img_pkg::pxl_t    proc_pxl,  // pixel or black
  output logic             is_red     // pixel counts as red
);

  import img_pkg::*;

  chan_t green; // green channel of the pixel
  chan_t blue;
  logic  pass;  // pixel survives the filter

  assign green = orig_pxl[green_msb -: chan_bits];
  assign blue  = orig_pxl[blue_msb -: chan_bits];

  // strong red with weak green and blue
  assign is_red = orig_pxl[red_msb] && (green < green_limit) && (blue < blue_limit);

  always_comb begin
    case (rgbfilter)
      filt_none: pass = 1'b1;   // no filtering
      filt_red:  pass = is_red; // red detector only
      default: begin
        // every selected channel needs its msb set, unselected ones don't care
        pass = (~rgbfilter[2] | orig_pxl[red_msb]) &
               (~rgbfilter[1] | orig_pxl[green_msb]) &
               (~rgbfilter[0] | orig_pxl[blue_msb]);
      end
    endcase
  end

  assign proc_pxl = pass ? orig_pxl : '0; // black when rejected

endmodule

// File: hdl/frame_buf.sv
module frame_buf (
  input  logic               clk,
  input  logic               we,      // write strobe
  input  img_pkg::pxl_addr_t wr_addr,
  input  img_pkg::pxl_t      wr_pxl,
  input  img_pkg::pxl_addr_t rd_addr,
  output img_pkg::pxl_t      rd_pxl   // valid one clock after rd_addr
);

  import img_pkg::*;

  // one frame of pixels, block ram style
  pxl_t mem [img_pxls];

  // write port, addresses past the frame are dropped
  always_ff @(posedge clk) begin
    if (we && (wr_addr < pxl_addr_t'(img_pxls))) begin
      mem[wr_addr] <= wr_pxl;
    end
  end

  // registered read port
  always_ff @(posedge clk) begin
    rd_pxl <= mem[rd_addr];
  end

endmodule

// File: common/track_pkg.sv
package track_pkg;

  // inner frame, 64 columns by 48 rows, border is ignored by the tracker
  localparam int inframe_col_lo = 8;
  localparam int inframe_col_hi = 71;
  localparam int inframe_row_lo = 6;
  localparam int inframe_row_hi = 53;

  // column histogram
  localparam int hist_bins = 8;
  localparam int bin_shift = 3; // 8 columns per bin

  typedef logic [2:0]  bin_t;       // bin index
  typedef logic [8:0]  hist_cnt_t;  // one bin, max 8*48 = 384
  typedef logic [11:0] total_cnt_t; // whole inner frame, max 3072
  typedef logic [10:0] side_cnt_t;  // up to four bins, max 1536

  // led pattern, bit 0 is the leftmost bin
  typedef logic [7:0] led_t;

endpackage

// File: common/img_pkg.sv
package img_pkg;

  // frame geometry, scanned row by row from the top left corner
  localparam int img_cols = 80;
  localparam int img_rows = 60;
  localparam int img_pxls = img_cols * img_rows; // 4800 words per frame

  // rgb444 layout
  localparam int chan_bits = 4;
  localparam int red_msb   = 11;
  localparam int green_msb = 7;
  localparam int blue_msb  = 3;

  typedef logic [chan_bits-1:0]         chan_t;     // one color channel
  typedef logic [3*chan_bits-1:0]       pxl_t;      // red[11:8] green[7:4] blue[3:0]
  typedef logic [$clog2(img_pxls)-1:0]  pxl_addr_t; // 13 bits
  typedef logic [6:0]                   col_t;      // 0..79
  typedef logic [5:0]                   row_t;      // 0..59

  // display filter code, bit 2 red, bit 1 green, bit 0 blue
  typedef logic [2:0] filter_t;
  localparam filter_t filt_none = 3'b000; // pass everything
  localparam filter_t filt_red  = 3'b100; // use the red detector

  // a red pixel needs green and blue below these
  localparam chan_t green_limit = 4'd9;
  localparam chan_t blue_limit  = 4'd9;

endpackage
